//--- tb.f
source/vpu_pkg.sv
source/vec_issue_if.sv
source/vec_wb_if.sv
source/cmd_decoder.sv
source/register_file.sv
source/vector_lane_unit.sv
source/vpu_top.sv
tb/vpu_ref_pkg.sv
tb/vpu_tb.sv

//--- tb/vpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_tb import vpu_pkg::*, vpu_ref_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int drain_cycles = 4;
    // test 1 spends four cycles per command
    localparam int cmd_slots    = 32 * 4 + (58 + 300) + 200 + 200 + 10 + 5 * drain_cycles;
    localparam int cycle_limit  = cmd_slots + reset_cycles + 100;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    vec_op_t   cmd_op;
    reg_addr_t cmd_rd;
    reg_addr_t cmd_rs1;
    reg_addr_t cmd_rs2;
    reg_addr_t cmd_rs3;
    imm_t      cmd_imm;
    logic      cmd_error;
    logic      result_valid;
    reg_addr_t result_rd;
    vec_t      result_data;

    integer    seed;
    int        cycle = 0;
    int        checks = 0;
    int        errors = 0;
    logic      error_due = 1'b0;
    reg_addr_t exp_rd [$];
    vec_t      exp_data [$];
    int        exp_issued [$];  // cycle of the strobe

    vpu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_rd       (cmd_rd),
        .cmd_rs1      (cmd_rs1),
        .cmd_rs2      (cmd_rs2),
        .cmd_rs3      (cmd_rs3),
        .cmd_imm      (cmd_imm),
        .cmd_error    (cmd_error),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("run stopped after %0d cycles, the DUT did not finish", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($random(seed));
    endfunction

    // nonzero and leaves the preloaded constants alone
    function automatic reg_addr_t rand_dest();
        reg_addr_t r;
        r = rand_reg();
        while (r == '0 || r == ident_reg || r == gravity_reg) begin
            r = rand_reg();
        end
        return r;
    endfunction

    task automatic check_outputs();
        reg_addr_t rd_want;
        vec_t      data_want;
        int        issued;
        assert (cmd_error === error_due) else begin
            $display("Mismatch at %0t: cmd_error expected %b got %b",
                     $time, error_due, cmd_error);
            errors++;
        end
        error_due = 1'b0;
        if (result_valid === 1'b1) begin
            assert (exp_rd.size() > 0) else begin
                $display("at %0t a result strobe came with no command outstanding", $time);
                errors++;
            end
            if (exp_rd.size() > 0) begin
                rd_want   = exp_rd.pop_front();
                data_want = exp_data.pop_front();
                issued    = exp_issued.pop_front();
                checks++;
                assert (cycle - issued == 2) else begin
                    $display("Mismatch at %0t: result latency expected 2 got %0d",
                             $time, cycle - issued);
                    errors++;
                end
                assert (result_rd === rd_want) else begin
                    $display("Mismatch at %0t: result_rd expected %0d got %0d",
                             $time, rd_want, result_rd);
                    errors++;
                end
                assert (result_data === data_want) else begin
                    $display("Mismatch at %0t: result_data expected %h got %h",
                             $time, data_want, result_data);
                    errors++;
                end
            end
        end else begin
            assert (!(exp_issued.size() > 0 && cycle - exp_issued[0] >= 2)) else begin
                $display("at %0t no result strobe for the command issued at cycle %0d",
                         $time, exp_issued[0]);
                errors++;
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_issued.pop_front());
            end
        end
    endtask

    task automatic issue_cmd(vec_op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                             reg_addr_t rs3, imm_t imm);
        vec_t res;
        @(negedge clk);
        check_outputs();
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_rd    = rd;
        cmd_rs1   = rs1;
        cmd_rs2   = rs2;
        cmd_rs3   = rs3;
        cmd_imm   = imm;
        if (op == op_merge && rd == '0 && rs1 == '0 && rs2 == '0 && rs3 == '0) begin
            error_due = 1'b1;  // rejected with an error pulse and no result
        end else begin
            res = ref_result(op, rs1, rs2, rs3, imm);
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            exp_issued.push_back(cycle);
            model_write(rd, res);
        end
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            check_outputs();
            cmd_valid = 1'b0;
        end
    endtask

    task automatic report_test(int num, string name, int mark);
        idle_cycles(drain_cycles);
        $display("test %0d %s: %0d errors", num, name, errors - mark);
    endtask

    initial begin
        int        mark;
        reg_addr_t prev_rd;
        reg_addr_t rd;
        vec_op_t   op;
        imm_t      imm;
        seed      = 32'h94d2bfcb;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = op_mov;
        cmd_rd    = '0;
        cmd_rs1   = '0;
        cmd_rs2   = '0;
        cmd_rs3   = '0;
        cmd_imm   = '0;
        model_reset();
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        for (int r = 0; r < num_regs; r++) begin
            issue_cmd(op_mov, reg_addr_t'(r), reg_addr_t'(r), '0, '0, '0);
            idle_cycles(3);
        end
        report_test(1, "reset contents", mark);

        mark = errors;
        for (int r = 1; r < num_regs; r++) begin
            if (r != ident_reg && r != gravity_reg) begin  // mix constants and rescale
                issue_cmd(op_merge, reg_addr_t'(r), ident_reg, gravity_reg, '0,
                          imm_t'($random(seed)));
                issue_cmd(op_scale, reg_addr_t'(r), reg_addr_t'(r), '0, '0,
                          imm_t'($random(seed) % 16));
            end
        end
        for (int i = 0; i < 300; i++) begin
            op = vec_op_t'(1 + $unsigned($random(seed)) % 6);
            issue_cmd(op, rand_dest(), rand_reg(), rand_reg(), rand_reg(),
                      imm_t'($random(seed)));
        end
        report_test(2, "sign and selection ops", mark);

        mark = errors;
        for (int i = 0; i < 200; i++) begin
            // every fourth shift spans the full range and saturates
            imm = (i % 4 == 0) ? imm_t'($random(seed)) : imm_t'($random(seed) % 24);
            issue_cmd(op_scale, rand_dest(), rand_reg(), '0, '0, imm);
        end
        report_test(3, "exponent scaling", mark);

        mark = errors;
        prev_rd = rand_dest();
        issue_cmd(op_bcast, prev_rd, gravity_reg, '0, '0, 16'd2);
        for (int i = 0; i < 199; i++) begin
            op  = vec_op_t'($random(seed));
            imm = (op == op_scale) ? imm_t'($random(seed) % 8) : imm_t'($random(seed));
            rd  = rand_dest();
            issue_cmd(op, rd, prev_rd, rand_reg(), rand_reg(), imm);
            prev_rd = rd;
        end
        report_test(4, "back-to-back dependencies", mark);

        mark = errors;
        issue_cmd(op_neg, '0, ident_reg, '0, '0, '0);
        issue_cmd(op_mov, 5'd1, '0, '0, '0, '0);  // no forwarding from r0
        issue_cmd(op_bcast, '0, gravity_reg, '0, '0, 16'd2);
        idle_cycles(2);
        issue_cmd(op_mov, 5'd2, '0, '0, '0, '0);
        issue_cmd(op_merge, '0, '0, '0, '0, 16'hffff);
        idle_cycles(3);
        report_test(5, "register zero and rejection", mark);

        $display("%0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/vpu_ref_pkg.sv
`default_nettype none

package vpu_ref_pkg;

    import vpu_pkg::*;

    vec_t model_regs [num_regs];

    function automatic void model_reset();
        for (int r = 0; r < num_regs; r++) begin
            model_regs[r] = '0;
        end
        model_regs[ident_reg]   = ident_vec;
        model_regs[gravity_reg] = gravity_vec;
    endfunction

    function automatic lane_t get_lane(vec_t v, int i);
        return v[i*lane_width +: lane_width];
    endfunction

    // exponent field as an integer, saturating at both ends
    function automatic lane_t ref_scale(lane_t x, int shift);
        int e;
        e = int'(x[30:23]);
        if (e == 0 || e == 255) begin
            return x;
        end
        e = e + shift;
        if (e >= 255) begin
            return {x[31], 8'hff, 23'h0};
        end
        if (e <= 0) begin
            return {x[31], 31'h0};
        end
        return {x[31], e[7:0], x[22:0]};
    endfunction

    function automatic vec_t ref_result(vec_op_t op, reg_addr_t rs1, reg_addr_t rs2,
                                        reg_addr_t rs3, imm_t imm);
        vec_t  res;
        lane_t la;
        lane_t lb;
        lane_t lc;
        lane_t y;
        int    shift;
        shift = $signed(imm[8:0]);
        for (int i = 0; i < num_lanes; i++) begin
            la = get_lane(model_regs[rs1], i);
            lb = get_lane(model_regs[rs2], i);
            lc = get_lane(model_regs[rs3], i);
            case (op)
                op_mov:      y = la;
                op_neg:      y = la ^ 32'h8000_0000;
                op_abs:      y = la & 32'h7fff_ffff;
                op_copysign: y = (la & 32'h7fff_ffff) | (lb & 32'h8000_0000);
                op_merge:    y = imm[i] ? lb : la;
                op_bcast:    y = get_lane(model_regs[rs1], int'(imm[3:0]));
                op_signsel:  y = lc[31] ? lb : la;
                default:     y = ref_scale(la, shift);
            endcase
            res[i*lane_width +: lane_width] = y;
        end
        return res;
    endfunction

    function automatic void model_write(reg_addr_t rd, vec_t data);
        if (rd != '0) begin
            model_regs[rd] = data;  // r0 is hardwired zero
        end
    endfunction

endpackage

`default_nettype wire

//--- source/vpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module vpu_top import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmd_valid,
    input  vec_op_t   cmd_op,
    input  reg_addr_t cmd_rd,
    input  reg_addr_t cmd_rs1,
    input  reg_addr_t cmd_rs2,
    input  reg_addr_t cmd_rs3,
    input  imm_t      cmd_imm,

    output logic      cmd_error,

    output logic      result_valid,
    output reg_addr_t result_rd,
    output vec_t      result_data
);

    vec_t data_a;
    vec_t data_b;
    vec_t data_c;

    vec_issue_if issue_if ();
    vec_wb_if    wb_if ();

    cmd_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_rd    (cmd_rd),
        .cmd_rs1   (cmd_rs1),
        .cmd_rs2   (cmd_rs2),
        .cmd_rs3   (cmd_rs3),
        .cmd_imm   (cmd_imm),
        .cmd_error (cmd_error),
        .issue     (issue_if.issue_src)
    );

    // sources are read in the cycle the command sits in the issue stage
    register_file u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_r1 (issue_if.rs1),
        .addr_r2 (issue_if.rs2),
        .addr_r3 (issue_if.rs3),
        .data_r1 (data_a),
        .data_r2 (data_b),
        .data_r3 (data_c),
        .wb      (wb_if.wb_dst)
    );

    vector_lane_unit u_lanes (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue_if.issue_dst),
        .src_a        (data_a),
        .src_b        (data_b),
        .src_c        (data_c),
        .wb           (wb_if.wb_src),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- source/vector_lane_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vector_lane_unit import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    vec_issue_if.issue_dst issue,

    input  vec_t      src_a,
    input  vec_t      src_b,
    input  vec_t      src_c,

    vec_wb_if.wb_src  wb,

    output logic      result_valid,
    output reg_addr_t result_rd,
    output vec_t      result_data
);

    lane_idx_t bcast_idx;
    lane_t     bcast_lane;
    vec_t      result_next;
    logic      wen_q;

    // exponent add with saturation, zero and all-ones exponents pass through
    function automatic lane_t scale_lane(lane_t x, logic [8:0] shift);
        logic       sign;
        logic [7:0] exp_in;
        logic [9:0] exp_sum;

        sign    = x[31];
        exp_in  = x[30:23];
        exp_sum = {2'b00, exp_in} + {shift[8], shift};

        if ((exp_in == 8'h00) || (exp_in == 8'hff)) begin
            return x;
        end
        if ($signed(exp_sum) >= 10'sd255) begin
            return {sign, 8'hff, 23'h0};  // infinity
        end
        if ($signed(exp_sum) <= 10'sd0) begin
            return {sign, 31'h0};  // flush to signed zero
        end
        return {sign, exp_sum[7:0], x[22:0]};
    endfunction

    function automatic lane_t exec_lane(
        vec_op_t    op,
        lane_t      a,
        lane_t      b,
        lane_t      c,
        lane_t      bc,
        logic       mask_bit,
        logic [8:0] shift
    );
        case (op)
            op_mov:      return a;
            op_neg:      return {~a[31], a[30:0]};
            op_abs:      return {1'b0, a[30:0]};
            op_copysign: return {b[31], a[30:0]};
            op_merge:    return mask_bit ? b : a;
            op_bcast:    return bc;
            op_signsel:  return c[31] ? b : a;  // negative c picks b
            op_scale:    return scale_lane(a, shift);
            default:     return a;
        endcase
    endfunction

    assign bcast_idx  = issue.imm[3:0];
    assign bcast_lane = src_a[bcast_idx*lane_width +: lane_width];

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            result_next[i*lane_width +: lane_width] = exec_lane(
                issue.op,
                src_a[i*lane_width +: lane_width],
                src_b[i*lane_width +: lane_width],
                src_c[i*lane_width +: lane_width],
                bcast_lane,
                issue.imm[i],
                issue.imm[8:0]
            );
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            wen_q        <= 1'b0;
        end else begin
            result_valid <= issue.valid;
            wen_q        <= issue.valid && issue.wr_en;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            result_rd   <= issue.rd;
            result_data <= result_next;
        end
    end

    assign wb.wen  = wen_q;
    assign wb.addr = result_rd;
    assign wb.data = result_data;

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  reg_addr_t addr_r1,
    input  reg_addr_t addr_r2,
    input  reg_addr_t addr_r3,
    output vec_t      data_r1,
    output vec_t      data_r2,
    output vec_t      data_r3,

    vec_wb_if.wb_dst  wb
);

    vec_t vectors [num_regs];

    // write-through
    assign data_r1 = (wb.wen && (wb.addr == addr_r1)) ? wb.data : vectors[addr_r1];
    assign data_r2 = (wb.wen && (wb.addr == addr_r2)) ? wb.data : vectors[addr_r2];
    assign data_r3 = (wb.wen && (wb.addr == addr_r3)) ? wb.data : vectors[addr_r3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                if (i == int'(ident_reg)) begin
                    vectors[i] <= ident_vec;
                end else if (i == int'(gravity_reg)) begin
                    vectors[i] <= gravity_vec;
                end else begin
                    vectors[i] <= '0;
                end
            end
        end else if (wb.wen) begin
            vectors[wb.addr] <= wb.data;
        end
    end

endmodule

`default_nettype wire

//--- source/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cmd_valid,
    input  vec_op_t   cmd_op,
    input  reg_addr_t cmd_rd,
    input  reg_addr_t cmd_rs1,
    input  reg_addr_t cmd_rs2,
    input  reg_addr_t cmd_rs3,
    input  imm_t      cmd_imm,

    output logic      cmd_error,

    vec_issue_if.issue_src issue
);

    logic all_zero_regs;
    logic reject;
    logic accept;

    assign all_zero_regs = (cmd_rd == '0) && (cmd_rs1 == '0) &&
                           (cmd_rs2 == '0) && (cmd_rs3 == '0);

    // a merge of r0 with r0 into r0 can only give zero
    assign reject = cmd_valid && (cmd_op == op_merge) && all_zero_regs;
    assign accept = cmd_valid && !reject;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
            issue.wr_en <= 1'b0;
            cmd_error   <= 1'b0;
        end else begin
            issue.valid <= accept;
            issue.wr_en <= accept && (cmd_rd != '0);  // r0 stays zero
            cmd_error   <= reject;
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            issue.op  <= cmd_op;
            issue.rd  <= cmd_rd;
            issue.rs1 <= cmd_rs1;
            issue.rs2 <= cmd_rs2;
            issue.rs3 <= cmd_rs3;
            issue.imm <= cmd_imm;
        end
    end

endmodule

`default_nettype wire

//--- source/vec_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vec_wb_if import vpu_pkg::*; ();

    logic      wen;
    reg_addr_t addr;
    vec_t      data;

    modport wb_src (
        output wen, addr, data
    );

    modport wb_dst (
        input wen, addr, data
    );

endinterface

`default_nettype wire

//--- source/vec_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vec_issue_if import vpu_pkg::*; ();

    logic      valid;
    vec_op_t   op;
    reg_addr_t rd;
    logic      wr_en;  // low for rd 0
    imm_t      imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rs3;

    modport issue_src (
        output valid, op, rd, wr_en, imm,
        output rs1, rs2, rs3
    );

    modport issue_dst (
        input valid, op, rd, wr_en, imm,
        input rs1, rs2, rs3
    );

endinterface

`default_nettype wire

//--- source/vpu_pkg.sv
`default_nettype none

package vpu_pkg;

    localparam int num_lanes  = 16;
    localparam int lane_width = 32;
    localparam int num_regs   = 32;

    typedef logic [4:0]                        reg_addr_t;
    typedef logic [lane_width-1:0]             lane_t;
    typedef logic [num_lanes*lane_width-1:0]   vec_t;
    typedef logic [3:0]                        lane_idx_t;
    typedef logic [15:0]                       imm_t;  // mask, lane index or exponent shift

    typedef enum logic [2:0] {
        op_mov      = 3'd0,
        op_neg      = 3'd1,
        op_abs      = 3'd2,
        op_copysign = 3'd3,
        op_merge    = 3'd4,
        op_bcast    = 3'd5,
        op_signsel  = 3'd6,
        op_scale    = 3'd7
    } vec_op_t;

    localparam lane_t fp_one     = 32'h3f800000;
    localparam lane_t fp_gravity = 32'hc11cf5c3;  // -9.81

    // 3x3 identity, row-major in lanes 0..8
    localparam vec_t ident_vec = {
        224'h0,
        fp_one,
        96'h0,
        fp_one,
        96'h0,
        fp_one
    };

    // gravity on the z axis, lane 2
    localparam vec_t gravity_vec = {
        416'h0,
        fp_gravity,
        64'h0
    };

    localparam reg_addr_t ident_reg   = 5'd13;
    localparam reg_addr_t gravity_reg = 5'd14;

endpackage

`default_nettype wire
